/* cpuCoreTop.f */
hdl/cpuCorePkg.sv
hdl/aluDecimal.sv
hdl/commandQueue.sv
hdl/apbCommandPort.sv
hdl/executeUnit.sv
hdl/cpuCoreTop.sv
dv/cpuCore_checker.sv
dv/cpuCoreTb.sv

/* dv/cpuCoreTb.sv */
// cpu core testbench
// random APB command traffic checked against a reference model of A, X, Y and P
`timescale 1ns/10ps

module cpuCoreTb;

  localparam int ClkPeriod = 40;
  localparam int NumBinary = 40;
  localparam int BurstLen = 8;
  localparam int NumDecimal = 30;
  // one term per phase of the run
  localparam int TransferCount =
    4 + 3 * NumBinary + BurstLen + 4 + 4 + 3 * NumDecimal + 3 + 4;

  logic phi2 = 1'b0;
  logic rstN;
  logic psel;
  logic penable;
  logic pwrite;
  cpuCorePkg::addrT paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;

  // expected response of the open transfer
  logic expErr = 1'b0;
  cpuCorePkg::byteT expData = '0;
  logic transferDone = 1'b0;
  int errors = 0;

  // reference model indexed by register code
  cpuCorePkg::byteT model [4];
  cpuCorePkg::byteT modelP;

  cpuCoreTop dut (
    .phi2    (phi2),
    .rstN    (rstN),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #(ClkPeriod / 2) phi2 = ~phi2;

  // transfer end as seen at the last rising edge
  always @(posedge phi2) begin
    transferDone <= psel && penable && pready;
  end

  errMatches: assert property (@(posedge phi2) disable iff (!rstN)
      (psel && penable && pready) |-> (pslverr == expErr))
    else begin
      errors++;
      $display("CHECK FAILED time=%0t signal=pslverr expected=%b actual=%b",
               $time, expErr, $sampled(pslverr));
    end

  readMatches: assert property (@(posedge phi2) disable iff (!rstN)
      (psel && penable && pready && !pwrite && !expErr) |-> (prdata == {24'h0, expData}))
    else begin
      errors++;
      $display("CHECK FAILED time=%0t signal=prdata expected=%h actual=%h",
               $time, {24'h0, expData}, $sampled(prdata));
    end

  function automatic int bcdValue(input cpuCorePkg::byteT v);
    return 10 * int'(v[7:4]) + int'(v[3:0]);
  endfunction

  function automatic cpuCorePkg::byteT bcdByte(input int n);
    return cpuCorePkg::byteT'(((n / 10) << 4) | (n % 10));
  endfunction

  function automatic cpuCorePkg::byteT randomBcd();
    return bcdByte(int'($urandom_range(0, 99)));
  endfunction

  function automatic cpuCorePkg::addrT regAddr(input cpuCorePkg::regSelT sel);
    case (sel)
      cpuCorePkg::RegSelX: return cpuCorePkg::AddrX;
      cpuCorePkg::RegSelY: return cpuCorePkg::AddrY;
      default:             return cpuCorePkg::AddrA;
    endcase
  endfunction

  function automatic cpuCorePkg::byteT expectedFor(input cpuCorePkg::addrT addr);
    case (addr)
      cpuCorePkg::AddrA: return model[0];
      cpuCorePkg::AddrX: return model[1];
      cpuCorePkg::AddrY: return model[2];
      cpuCorePkg::AddrP: return modelP;
      default:           return 8'h00;
    endcase
  endfunction

  task automatic applyModel(input cpuCorePkg::aluOpT op, input cpuCorePkg::regSelT sel,
                            input cpuCorePkg::byteT b);
    cpuCorePkg::byteT a;
    cpuCorePkg::byteT nb;
    cpuCorePkg::byteT r;
    int unsignedSum;
    int signedSum;
    logic c;
    int dr;
    a = model[sel];
    c = modelP[cpuCorePkg::FlagC];
    nb = (op == cpuCorePkg::opSbc) ? ~b : b;
    r = a;
    case (op)
      cpuCorePkg::opLoad: r = b;
      cpuCorePkg::opAnd:  r = a & b;
      cpuCorePkg::opEor:  r = a ^ b;
      cpuCorePkg::opOr:   r = a | b;
      cpuCorePkg::opSetP: modelP = b & cpuCorePkg::StatusMask;
      cpuCorePkg::opLsr: begin
        r = a >> 1;
        modelP[cpuCorePkg::FlagC] = a[0];
      end
      default: begin
        // binary sum taken both as unsigned and as signed numbers
        unsignedSum = int'(a) + int'(nb) + int'(c);
        signedSum = int'($signed(a)) + int'($signed(nb)) + int'(c);
        r = 8'(unsignedSum);
        modelP[cpuCorePkg::FlagC] = (unsignedSum > 255);
        // decimal result wraps at 100
        // carry means above 99 or no borrow
        if (modelP[cpuCorePkg::FlagD]) begin
          dr = (op == cpuCorePkg::opAdc) ? bcdValue(a) + bcdValue(b) + int'(c)
                                         : bcdValue(a) - bcdValue(b) - 1 + int'(c);
          r = bcdByte((dr + 100) % 100);
          modelP[cpuCorePkg::FlagC] = (op == cpuCorePkg::opAdc) ? (dr > 99) : (dr >= 0);
        end
        modelP[cpuCorePkg::FlagV] = (signedSum > 127) || (signedSum < -128);
      end
    endcase
    if (op != cpuCorePkg::opSetP) begin
      model[sel] = r;
      modelP[cpuCorePkg::FlagN] = (op == cpuCorePkg::opLsr) ? 1'b0 : r[7];
      modelP[cpuCorePkg::FlagZ] = (r == 8'h00);
    end
  endtask

  // one APB transfer with setup then access until pready
  task automatic apbTransfer(input logic write, input cpuCorePkg::addrT addr,
                             input logic [31:0] data, input logic err,
                             input cpuCorePkg::byteT exp);
    @(negedge phi2);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = data;
    expErr = err;
    expData = exp;
    @(negedge phi2);
    penable = 1'b1;
    do @(negedge phi2); while (!transferDone);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic sendCommand(input cpuCorePkg::aluOpT op, input cpuCorePkg::regSelT sel,
                             input cpuCorePkg::byteT b);
    logic [31:0] word;
    word = (32'(op) << cpuCorePkg::CmdOpLsb) | (32'(sel) << cpuCorePkg::CmdRegLsb) |
           (32'(b) << cpuCorePkg::CmdOperandLsb);
    apbTransfer(1'b1, cpuCorePkg::AddrCmd, word, 1'b0, 8'h00);
    applyModel(op, sel, b);
  endtask

  task automatic readRegister(input cpuCorePkg::addrT addr);
    apbTransfer(1'b0, addr, 32'h0, 1'b0, expectedFor(addr));
  endtask

  task automatic readAll();
    readRegister(cpuCorePkg::AddrA);
    readRegister(cpuCorePkg::AddrX);
    readRegister(cpuCorePkg::AddrY);
    readRegister(cpuCorePkg::AddrP);
  endtask

  // any op except opSetP with D clear
  task automatic randomBinaryCommand(output cpuCorePkg::regSelT sel);
    cpuCorePkg::aluOpT op;
    op = cpuCorePkg::aluOpT'(3'($urandom_range(0, 6)));
    sel = 2'($urandom_range(0, 2));
    sendCommand(op, sel, 8'($urandom));
  endtask

  initial begin
    cpuCorePkg::regSelT sel;
    cpuCorePkg::aluOpT op;
    void'($urandom(32'h797b_85b4));
    foreach (model[i]) model[i] = 8'h00;
    modelP = 8'h00;
    rstN = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (3) @(negedge phi2);
    rstN = 1'b1;

    readAll();
    for (int i = 0; i < NumBinary; i++) begin
      randomBinaryCommand(sel);
      readRegister(regAddr(sel));
      readRegister(cpuCorePkg::AddrP);
    end

    // burst longer than the queue then one read of everything
    for (int i = 0; i < BurstLen; i++) randomBinaryCommand(sel);
    readAll();

    sendCommand(cpuCorePkg::opSetP, cpuCorePkg::RegSelA,
                8'(1 << cpuCorePkg::FlagD) | 8'($urandom_range(0, 1)));
    for (int r = 0; r < 3; r++) sendCommand(cpuCorePkg::opLoad, 2'(r), randomBcd());
    for (int i = 0; i < NumDecimal; i++) begin
      sel = 2'($urandom_range(0, 2));
      op = ($urandom_range(0, 1) == 0) ? cpuCorePkg::opAdc : cpuCorePkg::opSbc;
      sendCommand(op, sel, randomBcd());
      readRegister(regAddr(sel));
      readRegister(cpuCorePkg::AddrP);
    end

    apbTransfer(1'b0, cpuCorePkg::AddrCmd, 32'h0, 1'b1, 8'h00);
    apbTransfer(1'b1, cpuCorePkg::AddrA, $urandom, 1'b1, 8'h00);
    apbTransfer(1'b0, 8'h20, 32'h0, 1'b1, 8'h00);
    readAll();

    $display("errors: %0d value mismatches, %0d protocol violations",
             errors, dut.protocolCheck.violations);
    if (errors == 0 && dut.protocolCheck.violations == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(TransferCount * 20 * ClkPeriod + 200 * ClkPeriod);
    $display("timeout: the run did not finish in time, errors so far %0d", errors);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* dv/cpuCore_checker.sv */
// APB protocol checker for the cpu core
// bound into the top level, watches the handshake and the read data
`timescale 1ns/10ps

module cpuCoreChecker (
  input logic             phi2,
  input logic             rstN,
  input logic             psel,
  input logic             penable,
  input logic             pwrite,
  input cpuCorePkg::addrT paddr,
  input logic [31:0]      pwdata,
  input logic [31:0]      prdata,
  input logic             pready,
  input logic             pslverr
);

  int unsigned violations = 0;

  // ready and error only answer an access phase
  idleQuiet: assert property (@(posedge phi2) disable iff (!rstN)
      !(psel && penable) |-> (!pready && !pslverr))
    else begin
      violations++;
      $error("pready or pslverr high outside an access phase");
    end

  errWithReady: assert property (@(posedge phi2) disable iff (!rstN)
      pslverr |-> pready)
    else begin
      violations++;
      $error("pslverr set without pready");
    end

  // request must hold while the slave stalls
  stallStable: assert property (@(posedge phi2) disable iff (!rstN)
      (psel && penable && !pready) |=> (psel && $stable(paddr) && $stable(pwdata)))
    else begin
      violations++;
      $error("request changed during a stalled access");
    end

  readKnown: assert property (@(posedge phi2) disable iff (!rstN)
      (psel && penable && pready && !pwrite) |-> !$isunknown(prdata))
    else begin
      violations++;
      $error("unknown value on prdata at read completion");
    end

endmodule

bind cpuCoreTop cpuCoreChecker protocolCheck (.*);

/* hdl/aluDecimal.sv */
// ALU with decimal adjust
// binary and BCD add and subtract, logic ops and shift right, with N V Z C outputs
`timescale 1ns/10ps

module aluDecimal (
  input  cpuCorePkg::aluOpT op,
  input  cpuCorePkg::byteT  a,
  input  cpuCorePkg::byteT  b,
  input  logic              carryIn,
  input  logic              decimalMode,
  output cpuCorePkg::byteT  result,
  output logic              carryOut,
  output logic              overflow,
  output logic              negative,
  output logic              zero
);

  cpuCorePkg::byteT bIn;
  logic [8:0] binSum;
  logic binOverflow;
  logic borrowIn;

  // decimal add, nibble at a time
  logic [4:0] addLo;
  logic [4:0] addHi;
  logic addHalfCarry;
  logic addCarry;
  logic [3:0] addLoAdj;
  logic [3:0] addHiAdj;

  // decimal subtract, nibble at a time
  logic [4:0] subLo;
  logic [4:0] subHi;
  logic subLoBorrow;
  logic subHiBorrow;
  logic [3:0] subLoAdj;
  logic [3:0] subHiAdj;

  // subtract is an add of the inverted operand
  assign bIn = (op == cpuCorePkg::opSbc) ? ~b : b;
  assign binSum = {1'b0, a} + {1'b0, bIn} + 9'(carryIn);
  // same-sign inputs giving an opposite-sign sum
  assign binOverflow = (a[7] == bIn[7]) & (binSum[7] != a[7]);

  assign addLo = {1'b0, a[3:0]} + {1'b0, b[3:0]} + 5'(carryIn);
  assign addHalfCarry = (addLo > 5'd9);
  assign addLoAdj = addHalfCarry ? addLo[3:0] + 4'd6 : addLo[3:0];
  assign addHi = {1'b0, a[7:4]} + {1'b0, b[7:4]} + 5'(addHalfCarry);
  assign addCarry = (addHi > 5'd9);
  assign addHiAdj = addCarry ? addHi[3:0] + 4'd6 : addHi[3:0];

  assign borrowIn = ~carryIn;
  assign subLo = {1'b0, a[3:0]} - {1'b0, b[3:0]} - 5'(borrowIn);
  assign subLoBorrow = subLo[4];
  assign subLoAdj = subLoBorrow ? subLo[3:0] - 4'd6 : subLo[3:0];
  assign subHi = {1'b0, a[7:4]} - {1'b0, b[7:4]} - 5'(subLoBorrow);
  assign subHiBorrow = subHi[4];
  assign subHiAdj = subHiBorrow ? subHi[3:0] - 4'd6 : subHi[3:0];

  always_comb begin
    result = b;
    carryOut = carryIn;
    overflow = 1'b0;
    case (op)
      cpuCorePkg::opLoad: result = b;
      cpuCorePkg::opAdc: begin
        result = decimalMode ? {addHiAdj, addLoAdj} : binSum[7:0];
        carryOut = decimalMode ? addCarry : binSum[8];
        overflow = binOverflow;
      end
      cpuCorePkg::opSbc: begin
        result = decimalMode ? {subHiAdj, subLoAdj} : binSum[7:0];
        // carry set means no borrow
        carryOut = decimalMode ? ~subHiBorrow : binSum[8];
        overflow = binOverflow;
      end
      cpuCorePkg::opAnd: result = a & b;
      cpuCorePkg::opEor: result = a ^ b;
      cpuCorePkg::opOr:  result = a | b;
      cpuCorePkg::opLsr: begin
        result = {1'b0, a[7:1]};
        carryOut = a[0];
      end
      default: result = b;
    endcase
  end

  // N and Z follow the adjusted result
  assign negative = (op == cpuCorePkg::opLsr) ? 1'b0 : result[7];
  assign zero = (result == '0);

endmodule

/* hdl/apbCommandPort.sv */
// APB command port
// turns command writes into queue pushes and returns register values once the core is idle
`timescale 1ns/10ps

module apbCommandPort (
  input  logic                                  phi2,
  input  logic                                  rstN,
  input  logic                                  psel,
  input  logic                                  penable,
  input  logic                                  pwrite,
  input  cpuCorePkg::addrT                      paddr,
  input  logic [cpuCorePkg::ApbDataWidth-1:0]   pwdata,
  output logic [cpuCorePkg::ApbDataWidth-1:0]   prdata,
  output logic                                  pready,
  output logic                                  pslverr,
  output logic                                  pushValid,
  output cpuCorePkg::cmdT                       pushCmd,
  input  logic                                  full,
  input  logic                                  queueEmpty,
  input  logic                                  busy,
  input  cpuCorePkg::byteT                      regA,
  input  cpuCorePkg::byteT                      regX,
  input  cpuCorePkg::byteT                      regY,
  input  cpuCorePkg::byteT                      regP
);

  logic access;
  logic addrIsCmd;
  logic addrIsReg;
  logic cmdWrite;
  logic regRead;
  logic badAccess;
  logic drained;
  cpuCorePkg::byteT readByte;

  // access phase of a transfer
  assign access = psel & penable;

  // address decode
  assign addrIsCmd = (paddr == cpuCorePkg::AddrCmd);
  assign addrIsReg = (paddr == cpuCorePkg::AddrA) |
                     (paddr == cpuCorePkg::AddrX) |
                     (paddr == cpuCorePkg::AddrY) |
                     (paddr == cpuCorePkg::AddrP);

  assign cmdWrite = pwrite & addrIsCmd;
  assign regRead = ~pwrite & addrIsReg;
  // wrong direction or unmapped address
  assign badAccess = ~(cmdWrite | regRead);

  // push lands on the edge that ends the write
  assign pushValid = access & cmdWrite & ~full;

  // field by field repack of the command word
  assign pushCmd = {
    pwdata[cpuCorePkg::CmdOpLsb +: $bits(cpuCorePkg::aluOpT)],
    pwdata[cpuCorePkg::CmdRegLsb +: $bits(cpuCorePkg::regSelT)],
    pwdata[cpuCorePkg::CmdOperandLsb +: $bits(cpuCorePkg::byteT)]
  };

  // pipeline drain status, sampled one cycle early
  // no push can slip in behind it while a read is open, so it stays exact
  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      drained <= 1'b0;
    end else begin
      drained <= queueEmpty & ~busy & ~pushValid;
    end
  end

  // writes stall on a full queue, reads stall until every earlier command has retired
  assign pready = access & (badAccess | (cmdWrite & ~full) | (regRead & drained));
  assign pslverr = access & badAccess;

  // read data select
  always_comb begin
    case (paddr)
      cpuCorePkg::AddrA: readByte = regA;
      cpuCorePkg::AddrX: readByte = regX;
      cpuCorePkg::AddrY: readByte = regY;
      cpuCorePkg::AddrP: readByte = regP;
      default:           readByte = '0;
    endcase
  end

  assign prdata = {
    {(cpuCorePkg::ApbDataWidth - $bits(cpuCorePkg::byteT)){1'b0}},
    readByte
  };

endmodule

/* hdl/commandQueue.sv */
// command queue
// circular FIFO of command entries between the APB port and the execution unit
`timescale 1ns/10ps

module commandQueue (
  input  logic            phi2,
  input  logic            rstN,
  input  logic            pushValid,
  input  cpuCorePkg::cmdT pushCmd,
  output logic            full,
  output logic            popValid,
  output cpuCorePkg::cmdT popCmd,
  input  logic            popReady,
  output logic            empty
);

  cpuCorePkg::cmdT mem [cpuCorePkg::QueueDepth];
  logic [cpuCorePkg::QueuePtrWidth-1:0]   wrPtr;
  logic [cpuCorePkg::QueuePtrWidth-1:0]   rdPtr;
  logic [cpuCorePkg::QueueCountWidth-1:0] count;
  logic doPush;
  logic doPop;

  assign full = (count == cpuCorePkg::QueueCountWidth'(cpuCorePkg::QueueDepth));
  assign empty = (count == '0);
  assign popValid = ~empty;
  assign popCmd = mem[rdPtr];

  assign doPush = pushValid & ~full;
  assign doPop = popValid & popReady;

  // entry storage
  always_ff @(posedge phi2) begin
    if (doPush) begin
      mem[wrPtr] <= pushCmd;
    end
  end

  // pointers wrap at the last slot
  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == cpuCorePkg::QueuePtrWidth'(cpuCorePkg::QueueDepth - 1)) ?
                 '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == cpuCorePkg::QueuePtrWidth'(cpuCorePkg::QueueDepth - 1)) ?
                 '0 : rdPtr + 1'b1;
      end
      // simultaneous push and pop leave the count alone
      if (doPush && !doPop) begin
        count <= count + 1'b1;
      end else if (doPop && !doPush) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* hdl/cpuCorePkg.sv */
// cpu core shared definitions
// data widths, APB address map, command word layout, ALU operations and status flags
package cpuCorePkg;

  // data path widths
  typedef logic [7:0] byteT;
  typedef logic [7:0] addrT;
  typedef logic [1:0] regSelT;

  typedef enum logic [2:0] {
    opLoad = 3'd0,
    opAdc  = 3'd1,
    opSbc  = 3'd2,
    opAnd  = 3'd3,
    opEor  = 3'd4,
    opOr   = 3'd5,
    opLsr  = 3'd6,
    opSetP = 3'd7
  } aluOpT;

  // command word fields, a queue entry keeps the same bit layout
  localparam int CmdOperandLsb = 0;
  localparam int CmdRegLsb = 8;
  localparam int CmdOpLsb = 10;
  localparam int CmdWidth = CmdOpLsb + $bits(aluOpT);

  typedef logic [CmdWidth-1:0] cmdT;

  // target register codes
  localparam regSelT RegSelA = 2'd0;
  localparam regSelT RegSelX = 2'd1;
  localparam regSelT RegSelY = 2'd2;

  localparam int ApbDataWidth = 32;

  // command queue sizing
  localparam int QueueDepth = 4;
  localparam int QueuePtrWidth = $clog2(QueueDepth);
  localparam int QueueCountWidth = $clog2(QueueDepth + 1);

  // APB address map
  localparam addrT AddrCmd = 8'h00;
  localparam addrT AddrA = 8'h04;
  localparam addrT AddrX = 8'h08;
  localparam addrT AddrY = 8'h0C;
  localparam addrT AddrP = 8'h10;

  // status register bit positions
  localparam int FlagN = 7;
  localparam int FlagV = 6;
  localparam int FlagD = 3;
  localparam int FlagZ = 1;
  localparam int FlagC = 0;

  // bits that exist in P, the rest read as zero
  localparam byteT StatusMask =
    byteT'((1 << FlagN) | (1 << FlagV) | (1 << FlagD) | (1 << FlagZ) | (1 << FlagC));

endpackage

/* hdl/cpuCoreTop.sv */
// cpu core top level
// APB command port feeding the command queue and the execution unit
`timescale 1ns/10ps

module cpuCoreTop (
  input  logic                                phi2,
  input  logic                                rstN,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  cpuCorePkg::addrT                    paddr,
  input  logic [cpuCorePkg::ApbDataWidth-1:0] pwdata,
  output logic [cpuCorePkg::ApbDataWidth-1:0] prdata,
  output logic                                pready,
  output logic                                pslverr
);

  logic pushValid;
  logic full;
  logic popValid;
  logic popReady;
  logic queueEmpty;
  logic busy;
  cpuCorePkg::cmdT pushCmd;
  cpuCorePkg::cmdT popCmd;
  cpuCorePkg::byteT regA;
  cpuCorePkg::byteT regX;
  cpuCorePkg::byteT regY;
  cpuCorePkg::byteT regP;

  apbCommandPort cmdPort (
    .phi2       (phi2),
    .rstN       (rstN),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .pushValid  (pushValid),
    .pushCmd    (pushCmd),
    .full       (full),
    .queueEmpty (queueEmpty),
    .busy       (busy),
    .regA       (regA),
    .regX       (regX),
    .regY       (regY),
    .regP       (regP)
  );

  commandQueue cmdQueue (
    .phi2      (phi2),
    .rstN      (rstN),
    .pushValid (pushValid),
    .pushCmd   (pushCmd),
    .full      (full),
    .popValid  (popValid),
    .popCmd    (popCmd),
    .popReady  (popReady),
    .empty     (queueEmpty)
  );

  executeUnit execUnit (
    .phi2     (phi2),
    .rstN     (rstN),
    .popValid (popValid),
    .popCmd   (popCmd),
    .popReady (popReady),
    .busy     (busy),
    .regA     (regA),
    .regX     (regX),
    .regY     (regY),
    .regP     (regP)
  );

endmodule

/* hdl/executeUnit.sv */
// execution unit
// applies queued commands to the A, X, Y and status registers through the ALU
`timescale 1ns/10ps

module executeUnit (
  input  logic             phi2,
  input  logic             rstN,
  input  logic             popValid,
  input  cpuCorePkg::cmdT  popCmd,
  output logic             popReady,
  output logic             busy,
  output cpuCorePkg::byteT regA,
  output cpuCorePkg::byteT regX,
  output cpuCorePkg::byteT regY,
  output cpuCorePkg::byteT regP
);

  cpuCorePkg::cmdT    stagedCmd;
  cpuCorePkg::aluOpT  op;
  cpuCorePkg::regSelT target;
  cpuCorePkg::byteT   operand;
  cpuCorePkg::byteT   targetVal;
  cpuCorePkg::byteT   aluResult;
  cpuCorePkg::byteT   nextP;
  logic aluCarry;
  logic aluOverflow;
  logic aluNegative;
  logic aluZero;

  // every command takes one write-back cycle, so the unit never stalls
  assign popReady = 1'b1;

  // command held for its write-back cycle
  always_ff @(posedge phi2) begin
    if (popValid && popReady) begin
      stagedCmd <= popCmd;
    end
  end

  assign op = cpuCorePkg::aluOpT'(stagedCmd[cpuCorePkg::CmdOpLsb +: $bits(cpuCorePkg::aluOpT)]);
  assign target = stagedCmd[cpuCorePkg::CmdRegLsb +: $bits(cpuCorePkg::regSelT)];
  assign operand = stagedCmd[cpuCorePkg::CmdOperandLsb +: $bits(cpuCorePkg::byteT)];

  // target register feeds the ALU, code 3 falls back to A
  always_comb begin
    case (target)
      cpuCorePkg::RegSelA: targetVal = regA;
      cpuCorePkg::RegSelX: targetVal = regX;
      cpuCorePkg::RegSelY: targetVal = regY;
      default:             targetVal = regA;
    endcase
  end

  aluDecimal alu (
    .op          (op),
    .a           (targetVal),
    .b           (operand),
    .carryIn     (regP[cpuCorePkg::FlagC]),
    .decimalMode (regP[cpuCorePkg::FlagD]),
    .result      (aluResult),
    .carryOut    (aluCarry),
    .overflow    (aluOverflow),
    .negative    (aluNegative),
    .zero        (aluZero)
  );

  // flag update per operation
  always_comb begin
    nextP = regP;
    case (op)
      cpuCorePkg::opSetP: nextP = operand & cpuCorePkg::StatusMask;
      cpuCorePkg::opAdc, cpuCorePkg::opSbc: begin
        nextP[cpuCorePkg::FlagC] = aluCarry;
        nextP[cpuCorePkg::FlagV] = aluOverflow;
        nextP[cpuCorePkg::FlagN] = aluNegative;
        nextP[cpuCorePkg::FlagZ] = aluZero;
      end
      cpuCorePkg::opLsr: begin
        nextP[cpuCorePkg::FlagC] = aluCarry;
        nextP[cpuCorePkg::FlagN] = aluNegative;
        nextP[cpuCorePkg::FlagZ] = aluZero;
      end
      default: begin
        nextP[cpuCorePkg::FlagN] = aluNegative;
        nextP[cpuCorePkg::FlagZ] = aluZero;
      end
    endcase
  end

  // write-back, one cycle after the pop
  always_ff @(posedge phi2 or negedge rstN) begin
    if (!rstN) begin
      busy <= 1'b0;
      regA <= '0;
      regX <= '0;
      regY <= '0;
      regP <= '0;
    end else begin
      busy <= popValid & popReady;
      if (busy) begin
        regP <= nextP;
        if (op != cpuCorePkg::opSetP) begin
          case (target)
            cpuCorePkg::RegSelX: regX <= aluResult;
            cpuCorePkg::RegSelY: regY <= aluResult;
            default:             regA <= aluResult;
          endcase
        end
      end
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuCoreTb -f cpuCoreTop.f

output=$(./obj_dir/VcpuCoreTb +verilator+error+limit+1000)
echo "$output"

if grep -qx "Simulation finished: PASS" <<< "$output"; then
  exit 0
fi
exit 1
